//--- sources.f
+incdir+hw
hw/midi_pkg.sv
hw/midi_serial_rx.sv
hw/midi_note_parser.sv
hw/midi_key_matrix.sv
hw/midi_uart_regs.sv
hw/midi_uart_top.sv
test/midi_uart_tb.sv

//--- Makefile
TOP := midi_uart_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module midi_uart_top

obj_dir/V$(TOP): sources.f hw/*.sv hw/*.svh test/*.sv
	verilator --binary --timing --assert -j 0 -f sources.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- test/midi_uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module midi_uart_tb;

    localparam int cpb = `MIDI_CLKS_PER_BIT;
    // Longest wait, well above one frame
    localparam int wait_limit = 40 * cpb;

    logic       cpu_bus;
    logic       rst_n;
    logic       cs;
    logic [2:0] addr;
    logic [7:0] wdata;
    logic       wr;
    logic       rd;
    logic       int_ack;
    logic       midi_in;
    wire  [7:0] rdata;
    wire        irq;

    // Model of the last loaded command and of the key matrix
    midi_pkg::cmd_t    cmd_model;
    midi_pkg::cmd_t    cmd_val;
    midi_pkg::status_t exp_st;
    logic [7:0]        key_model [8];
    logic [15:0]       lfsr_q;
    logic [7:0]        b1;
    logic [7:0]        b2;
    logic [7:0]        b3;
    logic [7:0]        b4;

    midi_uart_top i_dut (
        .cpu_bus (cpu_bus),
        .rst_n   (rst_n),
        .cs      (cs),
        .addr    (addr),
        .wdata   (wdata),
        .wr      (wr),
        .rd      (rd),
        .int_ack (int_ack),
        .midi_in (midi_in),
        .rdata   (rdata),
        .irq     (irq)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #10 cpu_bus = ~cpu_bus;
    end

    task automatic fail_value(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        $display("ERR %s got %h expected %h", name, got, exp);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic fail_text(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [7:0] lfsr_byte(input int nbits);
        logic [7:0] v;
        logic       fb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[6:0], fb};
        end
        return v;
    endfunction

    task automatic bus_write(input logic [2:0] a, input logic [7:0] d);
        @(posedge cpu_bus);
        #1;
        cs    = 1'b1;
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        @(posedge cpu_bus);
        #1;
        cs = 1'b0;
        wr = 1'b0;
    endtask

    // Command model follows only commands that load the register
    task automatic write_cmd(input midi_pkg::cmd_t c);
        bus_write(midi_pkg::REG_CMD, c);
        if (!c.ir && !c.er) cmd_model = c;
    endtask

    // rdata is combinational, sampled mid-cycle
    task automatic expect_read(input logic [2:0] a, input logic [7:0] exp,
                               input string name);
        logic [7:0] got;
        @(posedge cpu_bus);
        #1;
        cs   = 1'b1;
        addr = a;
        rd   = 1'b1;
        @(negedge cpu_bus);
        got = rdata;
        @(posedge cpu_bus);
        #1;
        cs = 1'b0;
        rd = 1'b0;
        assert (got == exp) else fail_value(name, got, exp);
    endtask

    // Interrupt acknowledge cycle
    task automatic expect_vector(input logic [7:0] exp);
        logic [7:0] got;
        @(posedge cpu_bus);
        #1;
        cs      = 1'b1;
        rd      = 1'b1;
        int_ack = 1'b1;
        @(negedge cpu_bus);
        got = rdata;
        @(posedge cpu_bus);
        #1;
        cs      = 1'b0;
        rd      = 1'b0;
        int_ack = 1'b0;
        assert (got == exp) else fail_value("vector", got, exp);
    endtask

    task automatic wait_irq(input logic exp);
        int n;
        n = 0;
        while (irq !== exp && n < wait_limit) begin
            @(negedge cpu_bus);
            n++;
        end
        if (irq !== exp) fail_text("timeout while waiting for irq to change");
    endtask

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_frame(input logic [7:0] b, input logic bad_stop);
        logic [9:0] frame;
        frame = {~bad_stop, b, 1'b0};
        repeat (2) @(posedge cpu_bus);
        #1;
        for (int i = 0; i < 10; i++) begin
            midi_in = frame[i];
            repeat (cpb) @(posedge cpu_bus);
            #1;
        end
        midi_in = 1'b1;
    endtask

    // One byte through the buffer, rxie must be on
    task automatic take_byte(input logic [7:0] b);
        send_frame(b, 1'b0);
        wait_irq(1'b1);
        expect_read(midi_pkg::REG_DATA, b, "rx data");
        wait_irq(1'b0);
    endtask

    // Row from low bits, column from bits 5 to 3, pressed reads 0
    task automatic track_key(input logic [5:0] key, input logic down);
        key_model[key[2:0]][key[5:3]] = ~down;
    endtask

    a_irq_enabled: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        irq |-> (cmd_model.rxie | cmd_model.txie))
        else fail_value("irq", {7'd0, irq}, 8'h00);

    // Deselected bus reads FF
    a_idle_rdata: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        !cs |-> (rdata == 8'hFF))
        else fail_value("rdata", rdata, 8'hFF);

    initial begin
        rst_n     = 1'b0;
        cs        = 1'b0;
        addr      = '0;
        wdata     = '0;
        wr        = 1'b0;
        rd        = 1'b0;
        int_ack   = 1'b0;
        midi_in   = 1'b1;
        cmd_model = '0;
        lfsr_q    = 16'd41;
        for (int r = 0; r < 8; r++) key_model[r] = 8'hFF;
        repeat (4) @(posedge cpu_bus);
        #1 rst_n = 1'b1;

        // Reset state
        assert (irq === 1'b0) else fail_value("irq", {7'd0, irq}, 8'h00);
        expect_read(midi_pkg::REG_CMD, 8'h00, "status");
        bus_write(midi_pkg::REG_KEYROW, 8'hFF);
        expect_read(midi_pkg::REG_KEYROW, 8'hFF, "key_data");
        expect_read(3'd7, 8'hFF, "unmapped");

        // Receive with interrupt, vectors on acknowledge
        bus_write(midi_pkg::REG_VEC_MIDI, 8'hA5);
        bus_write(midi_pkg::REG_VEC_EXT, 8'h3C);
        cmd_val      = '0;
        cmd_val.rxen = 1'b1;
        cmd_val.rxie = 1'b1;
        write_cmd(cmd_val);
        // Seven bits only, so the parser sees data bytes and stays idle
        b1 = lfsr_byte(7);
        send_frame(b1, 1'b0);
        wait_irq(1'b1);
        exp_st       = '0;
        exp_st.rxrdy = 1'b1;
        expect_read(midi_pkg::REG_CMD, exp_st, "status");
        expect_vector(8'hA5);
        expect_read(midi_pkg::REG_DATA, b1, "rx data");
        wait_irq(1'b0);
        expect_read(midi_pkg::REG_CMD, 8'h00, "status");
        expect_vector(8'h3C);

        // Overrun keeps the first byte
        b2 = lfsr_byte(7);
        b3 = lfsr_byte(7);
        send_frame(b2, 1'b0);
        send_frame(b3, 1'b0);
        exp_st.oe = 1'b1;
        expect_read(midi_pkg::REG_CMD, exp_st, "status");
        expect_read(midi_pkg::REG_DATA, b2, "rx data");
        wait_irq(1'b0);
        cmd_val    = '0;
        cmd_val.er = 1'b1;
        write_cmd(cmd_val);
        expect_read(midi_pkg::REG_CMD, 8'h00, "status");
        // Command still has rxen and rxie
        b4 = lfsr_byte(7);
        take_byte(b4);

        // Bad stop bit sets FE, buffer and parser untouched
        send_frame(8'h90, 1'b1);
        exp_st    = '0;
        exp_st.fe = 1'b1;
        expect_read(midi_pkg::REG_CMD, exp_st, "status");
        assert (irq === 1'b0) else fail_value("irq", {7'd0, irq}, 8'h00);
        expect_read(midi_pkg::REG_DATA, b4, "rx data");
        write_cmd(cmd_val);
        expect_read(midi_pkg::REG_CMD, 8'h00, "status");
        bus_write(midi_pkg::REG_KEYROW, 8'h08);
        take_byte(8'h2B);
        take_byte(8'h40);
        expect_read(midi_pkg::REG_KEYROW, key_model[3], "key_data");

        // Note On, then release by running status with velocity 0
        take_byte(8'h90);
        take_byte(8'h2B);
        take_byte(8'h40);
        track_key(6'h2B, 1'b1);
        expect_read(midi_pkg::REG_KEYROW, key_model[3], "key_data");
        take_byte(8'h2B);
        take_byte(8'h00);
        track_key(6'h2B, 1'b0);
        expect_read(midi_pkg::REG_KEYROW, key_model[3], "key_data");
        // Control change ends running status
        take_byte(8'hB0);
        take_byte(8'h2B);
        take_byte(8'h40);
        expect_read(midi_pkg::REG_KEYROW, key_model[3], "key_data");

        // Transmit flags, then internal reset
        cmd_val      = '0;
        cmd_val.rxen = 1'b1;
        cmd_val.rxie = 1'b1;
        cmd_val.txen = 1'b1;
        cmd_val.txie = 1'b1;
        write_cmd(cmd_val);
        wait_irq(1'b1);
        exp_st       = '0;
        exp_st.txrdy = 1'b1;
        expect_read(midi_pkg::REG_CMD, exp_st, "status");
        cmd_val    = '0;
        cmd_val.ir = 1'b1;
        write_cmd(cmd_val);
        wait_irq(1'b0);
        expect_read(midi_pkg::REG_CMD, 8'h00, "status");

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/midi_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module midi_uart_top (
    input  wire        cpu_bus,
    input  wire        rst_n,
    input  wire        cs,
    input  wire  [2:0] addr,
    input  wire  [7:0] wdata,
    input  wire        wr,
    input  wire        rd,
    input  wire        int_ack,
    input  wire        midi_in,
    output logic [7:0] rdata,
    output logic       irq
);

    logic                 rx_strobe;
    midi_pkg::rx_byte_t   rx_byte;
    logic                 key_strobe;
    midi_pkg::key_event_t key_event;
    midi_pkg::row_mask_t  key_row;
    logic [7:0]           key_data;

    // Serial pin to bytes
    midi_serial_rx i_rx (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .midi_in   (midi_in),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

    // Bytes to key events
    midi_note_parser i_parser (
        .cpu_bus    (cpu_bus),
        .rst_n      (rst_n),
        .rx_strobe  (rx_strobe),
        .rx_byte    (rx_byte),
        .key_strobe (key_strobe),
        .key_event  (key_event)
    );

    midi_key_matrix i_matrix (
        .cpu_bus    (cpu_bus),
        .rst_n      (rst_n),
        .key_strobe (key_strobe),
        .key_event  (key_event),
        .key_row    (key_row),
        .key_data   (key_data)
    );

    // CPU side
    midi_uart_regs i_regs (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .cs        (cs),
        .addr      (addr),
        .wdata     (wdata),
        .wr        (wr),
        .rd        (rd),
        .int_ack   (int_ack),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte),
        .key_data  (key_data),
        .key_row   (key_row),
        .rdata     (rdata),
        .irq       (irq)
    );

endmodule

`default_nettype wire

//--- hw/midi_uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module midi_uart_regs (
    input  wire                 cpu_bus,
    input  wire                 rst_n,
    input  wire                 cs,
    input  wire  [2:0]          addr,
    input  wire  [7:0]          wdata,
    input  wire                 wr,
    input  wire                 rd,
    input  wire                 int_ack,
    input  wire                 rx_strobe,
    input  midi_pkg::rx_byte_t  rx_byte,
    input  wire  [7:0]          key_data,
    output midi_pkg::row_mask_t key_row,
    output logic [7:0]          rdata,
    output logic                irq
);

    midi_pkg::cmd_t    cmd;
    midi_pkg::status_t status;
    logic [7:0]        vec_midi;
    logic [7:0]        vec_ext;
    logic [7:0]        rx_buf;
    logic              rx_irq;
    logic              tx_irq;

    // Incoming command as fields
    midi_pkg::cmd_t cmd_in;
    assign cmd_in = midi_pkg::cmd_t'(wdata);

    wire bus_wr   = cs & wr;
    // Acknowledge cycles never count as register reads
    wire bus_rd   = cs & rd & ~int_ack;
    wire cmd_wr   = bus_wr & (addr == midi_pkg::REG_CMD);
    wire data_rd  = bus_rd & (addr == midi_pkg::REG_DATA);
    wire rx_take  = rx_strobe & cmd.rxen;
    wire rx_store = rx_take & ~rx_byte.frame_err & ~status.rxrdy;

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            cmd      <= '0;
            status   <= '0;
            vec_midi <= 8'hFF;
            vec_ext  <= 8'hFF;
            key_row  <= '0;
            rx_irq   <= 1'b0;
            tx_irq   <= 1'b0;
            irq      <= 1'b0;
        end else begin
            irq <= rx_irq | tx_irq;
            if (bus_wr) begin
                case (addr)
                    midi_pkg::REG_KEYROW:   key_row  <= midi_pkg::row_mask_t'(wdata);
                    midi_pkg::REG_VEC_MIDI: vec_midi <= wdata;
                    midi_pkg::REG_VEC_EXT:  vec_ext  <= wdata;
                    // Data writes go nowhere, there is no transmitter
                    default: ;
                endcase
            end
            if (cmd_wr) begin
                if (cmd_in.ir) begin
                    // Internal reset, command itself stays
                    status <= '0;
                    rx_irq <= 1'b0;
                    tx_irq <= 1'b0;
                end else if (cmd_in.er) begin
                    status.oe <= 1'b0;
                    status.fe <= 1'b0;
                end else begin
                    cmd <= cmd_in;
                    if (!cmd_in.rxen) begin
                        status.rxrdy <= 1'b0;
                        rx_irq       <= 1'b0;
                    end else begin
                        // A byte already waiting interrupts at once
                        rx_irq <= cmd_in.rxie & status.rxrdy;
                    end
                    if (!cmd_in.txen) begin
                        status.txrdy <= 1'b0;
                        tx_irq       <= 1'b0;
                    end else if (!cmd.txen) begin
                        // Transmitter switched on, buffer is empty
                        status.txrdy <= 1'b1;
                        tx_irq       <= cmd_in.txie;
                    end else if (!cmd_in.txie) begin
                        tx_irq <= 1'b0;
                    end
                end
            end
            // Receive path
            if (rx_take) begin
                if (rx_byte.frame_err) begin
                    status.fe <= 1'b1;
                end else if (status.rxrdy) begin
                    // Old byte not read yet, keep it
                    status.oe <= 1'b1;
                end else begin
                    status.rxrdy <= 1'b1;
                    if (cmd.rxie) rx_irq <= 1'b1;
                end
            end
            // Reading the buffer frees it
            if (data_rd) begin
                status.rxrdy <= 1'b0;
                rx_irq       <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (cmd_wr && cmd_in.ir) begin
            rx_buf <= '0;
        end else if (rx_store) begin
            rx_buf <= rx_byte.data;
        end
    end

    // Read mux, vector has priority during acknowledge
    always_comb begin
        rdata = 8'hFF;
        if (cs && int_ack) begin
            rdata = irq ? vec_midi : vec_ext;
        end else if (bus_rd) begin
            case (addr)
                midi_pkg::REG_KEYROW: rdata = key_data;
                midi_pkg::REG_DATA:   rdata = rx_buf;
                midi_pkg::REG_CMD:    rdata = status;
                default:              rdata = 8'hFF;
            endcase
        end
    end

    a_oe_needs_rxrdy: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        $rose(status.oe) |-> $past(status.rxrdy))
        else $error("OE set without a pending byte");

    // irq lags the flags by one cycle, so the enables are checked one cycle back
    a_irq_enabled: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        irq |-> $past(cmd.rxie | cmd.txie))
        else $error("irq high with both interrupt enables clear");

endmodule

`default_nettype wire

//--- hw/midi_key_matrix.sv
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module midi_key_matrix (
    input  wire                  cpu_bus,
    input  wire                  rst_n,
    input  wire                  key_strobe,
    input  midi_pkg::key_event_t key_event,
    input  midi_pkg::row_mask_t  key_row,
    output logic [7:0]           key_data
);

    // Active low, a pressed key reads 0
    logic [`MIDI_KEY_ROWS-1:0][7:0] keys_q;

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            keys_q <= '1;
        end else if (key_strobe) begin
            // Low 3 bits pick the row, upper 3 the column
            keys_q[key_event.key[2:0]][key_event.key[5:3]] <= ~key_event.down;
        end
    end

    // Several selected rows merge, like a real scanned keyboard
    always_comb begin
        key_data = '1;
        for (int r = 0; r < `MIDI_KEY_ROWS; r++) begin
            if (key_row[r]) key_data &= keys_q[r];
        end
    end

endmodule

`default_nettype wire

//--- hw/midi_note_parser.sv
`timescale 1ns/1ps
`default_nettype none

module midi_note_parser (
    input  wire                  cpu_bus,
    input  wire                  rst_n,
    input  wire                  rx_strobe,
    input  midi_pkg::rx_byte_t   rx_byte,
    output logic                 key_strobe,
    output midi_pkg::key_event_t key_event
);

    typedef enum logic [1:0] {
        ps_idle, ps_note, ps_vel
    } state_t;

    state_t     state;
    logic       note_on;
    logic [5:0] note;

    // Only clean frames reach the state machine
    wire take       = rx_strobe & ~rx_byte.frame_err;
    wire is_status  = rx_byte.data[7];
    // 8x Note Off and 9x Note On on any channel
    wire is_note    = (rx_byte.data[7:5] == 3'b100);
    wire vel_strobe = take & ~is_status & (state == ps_vel);

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ps_idle;
            note_on    <= 1'b0;
            key_strobe <= 1'b0;
        end else begin
            key_strobe <= vel_strobe;
            if (take) begin
                if (is_status) begin
                    // Note status starts a message, anything else drops it
                    state   <= is_note ? ps_note : ps_idle;
                    note_on <= rx_byte.data[4];
                end else begin
                    case (state)
                        ps_note: state <= ps_vel;
                        // Running status, next pair reuses the same status
                        ps_vel:  state <= ps_note;
                        default: state <= ps_idle;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (take && !is_status && state == ps_note) note <= rx_byte.data[5:0];
        if (vel_strobe) begin
            key_event.key  <= note;
            // Note On with velocity 0 counts as a release
            key_event.down <= note_on & (rx_byte.data[6:0] != 7'd0);
        end
    end

    a_key_after_rx: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        key_strobe |-> $past(rx_strobe))
        else $error("key_strobe without a received byte");

endmodule

`default_nettype wire

//--- hw/midi_serial_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "midi_settings.svh"

module midi_serial_rx #(
    // Must be at least 10 so the start offset fits before mid-bit
    parameter int clks_per_bit = `MIDI_CLKS_PER_BIT
) (
    input  wire                  cpu_bus,
    input  wire                  rst_n,
    input  wire                  midi_in,
    output logic                 rx_strobe,
    output midi_pkg::rx_byte_t   rx_byte
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(clks_per_bit / 2 - 1);
    // Cycles already gone from the pin edge when the start state is entered
    localparam logic [cnt_w-1:0] start_ofs = cnt_w'(3);

    typedef enum logic [1:0] {
        rx_idle, rx_start, rx_data, rx_stop
    } state_t;

    state_t           state;
    logic [2:0]       sync_q;
    logic [cnt_w-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    // Synchronized line and its previous value
    wire line     = sync_q[1];
    wire fall     = ~sync_q[1] & sync_q[2];
    wire bit_tick = (clk_cnt == last_cnt);

    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            // Line idles high, so no false start edge out of reset
            sync_q    <= '1;
            state     <= rx_idle;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_strobe <= 1'b0;
        end else begin
            sync_q    <= {sync_q[1:0], midi_in};
            rx_strobe <= 1'b0;
            case (state)
                rx_idle: begin
                    if (fall) begin
                        state   <= rx_start;
                        clk_cnt <= start_ofs;
                    end
                end
                rx_start: begin
                    if (clk_cnt == half_cnt) begin
                        // Glitch shorter than half a bit, back to idle
                        state   <= line ? rx_idle : rx_data;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_data: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_stop: begin
                    if (bit_tick) begin
                        rx_strobe <= 1'b1;
                        state     <= rx_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge cpu_bus) begin
        if (state == rx_data && bit_tick) shift_q <= {line, shift_q[7:1]};
        if (state == rx_stop && bit_tick) begin
            rx_byte.data      <= shift_q;
            rx_byte.frame_err <= ~line;
        end
    end

    // At most one byte per frame, frames are many cycles long
    a_single_strobe: assert property (@(posedge cpu_bus) disable iff (!rst_n)
        rx_strobe |=> !rx_strobe)
        else $error("rx_strobe held for two cycles");

endmodule

`default_nettype wire

//--- hw/midi_pkg.sv
`default_nettype none

`include "midi_settings.svh"

package midi_pkg;

    // One received frame
    typedef struct packed {
        logic [7:0] data;
        // Stop bit sampled low
        logic       frame_err;
    } rx_byte_t;

    // One key change, note folded to 64 keys
    typedef struct packed {
        logic [5:0] key;
        logic       down;
    } key_event_t;

    // Row select mask towards the matrix
    typedef logic [`MIDI_KEY_ROWS-1:0] row_mask_t;

    // Command register, bit 0 is txen
    typedef struct packed {
        logic       ir;
        logic [1:0] spare;
        logic       er;
        logic       rxie;
        logic       rxen;
        logic       txie;
        logic       txen;
    } cmd_t;

    // Status register, bit 0 is txrdy
    typedef struct packed {
        logic [1:0] spare_hi;
        logic       fe;
        logic       oe;
        logic [1:0] spare_lo;
        logic       rxrdy;
        logic       txrdy;
    } status_t;

    // Register offsets on the 3-bit address
    localparam logic [2:0] REG_KEYROW   = 3'd2;
    localparam logic [2:0] REG_VEC_MIDI = 3'd3;
    localparam logic [2:0] REG_VEC_EXT  = 3'd4;
    localparam logic [2:0] REG_DATA     = 3'd5;
    // Command on writes, status on reads
    localparam logic [2:0] REG_CMD      = 3'd6;

endpackage

`default_nettype wire

//--- hw/midi_settings.svh
`ifndef MIDI_SETTINGS_SVH
`define MIDI_SETTINGS_SVH

// cpu_bus cycles per serial bit
// 16 keeps simulation short, a real 31250 baud link needs the true ratio
`define MIDI_CLKS_PER_BIT 16

// Rows of the key matrix, one byte of columns per row
`define MIDI_KEY_ROWS 8

`endif
